// File: sources.f
ddr_pkg.sv
ddr_write_fifo.sv
ddr_line_cache.sv
ddr_arbiter.sv
ddram.sv
ddr_mem_model.sv
tb_ddram.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_ddram
FILELIST = sources.f

SRCS = $(shell cat $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

// File: tb_ddram.sv
// simulation top that drives the three DDR front end clients and checks each read against a shadow
`default_nettype none
`timescale 1ns/1ps

module tb_ddram;

	// roughly 120 client operations of under 100 cycles each with stalls and some margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic CLK, rst_pulse;
	logic [17:0] ramh_addr, cdram_addr, vdp1fb_addr;
	logic [31:0] ramh_din, ramh_dout;
	logic [15:0] cdram_din, cdram_dout, vdp1fb_din, vdp1fb_dout;
	logic ramh_rd, cdram_rd, vdp1fb_rd;
	logic [3:0] ramh_wr;
	logic [1:0] cdram_wr, vdp1fb_wr;
	logic ramh_busy, cdram_busy, vdp1fb_busy;
	logic ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;
	logic [7:0] ddr_burstcnt, ddr_be;
	logic [28:0] ddr_addr;
	logic [63:0] ddr_dout, ddr_din;
	logic random_busy, hold_busy;
	int cycles;

	logic [7:0] shadow [longint];
	string name_q[$];
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];
	int rec_c[$];
	logic [17:0] rec_a[$];

	ddram dut (
		.CLK(CLK), .rst_pulse(rst_pulse),
		.ramh_addr(ramh_addr), .ramh_din(ramh_din), .ramh_rd(ramh_rd), .ramh_wr(ramh_wr),
		.ramh_dout(ramh_dout), .ramh_busy(ramh_busy),
		.cdram_addr(cdram_addr), .cdram_din(cdram_din), .cdram_rd(cdram_rd),
		.cdram_wr(cdram_wr), .cdram_dout(cdram_dout), .cdram_busy(cdram_busy),
		.vdp1fb_addr(vdp1fb_addr), .vdp1fb_din(vdp1fb_din), .vdp1fb_rd(vdp1fb_rd),
		.vdp1fb_wr(vdp1fb_wr), .vdp1fb_dout(vdp1fb_dout), .vdp1fb_busy(vdp1fb_busy),
		.DDRAM_BUSY(ddr_busy), .DDRAM_BURSTCNT(ddr_burstcnt), .DDRAM_ADDR(ddr_addr),
		.DDRAM_DOUT(ddr_dout), .DDRAM_DOUT_READY(ddr_dout_ready), .DDRAM_RD(ddr_rd),
		.DDRAM_DIN(ddr_din), .DDRAM_BE(ddr_be), .DDRAM_WE(ddr_we)
	);

	ddr_mem_model mem (
		.CLK(CLK), .random_busy(random_busy), .hold_busy(hold_busy),
		.addr(ddr_addr), .burstcnt(ddr_burstcnt), .be(ddr_be), .din(ddr_din),
		.rd(ddr_rd), .we(ddr_we), .busy(ddr_busy), .dout(ddr_dout),
		.dout_ready(ddr_dout_ready)
	);

	always #50 CLK = ~CLK;

	function automatic string client_name(input int c);
		case (c)
			0: return "ramh";
			1: return "cdram";
			default: return "vdp1fb";
		endcase
	endfunction

	function automatic logic busy_of(input int c);
		case (c)
			0: return ramh_busy;
			1: return cdram_busy;
			default: return vdp1fb_busy;
		endcase
	endfunction

	function automatic logic [31:0] dout_of(input int c);
		case (c)
			0: return ramh_dout;
			1: return {16'h0, cdram_dout};
			default: return {16'h0, vdp1fb_dout};
		endcase
	endfunction

	function automatic logic [25:0] half_addr(input int c, input logic [17:0] a);
		case (c)
			0: return 26'({a, 1'b0}) | ddr_pkg::RAMH_BASE;
			1: return 26'(a) | ddr_pkg::CDRAM_BASE;
			default: return 26'(a) | ddr_pkg::VDP1FB_BASE;
		endcase
	endfunction

	// DDR word address and byte lane of client byte i with the lowest address in the high lane
	function automatic longint byte_key(input int c, input logic [17:0] a, input int i);
		logic [25:0] hw;
		int lane_byte;
		hw = half_addr(c, a);
		lane_byte = (((c == 0) ? 2 : 3) - int'(hw[1:0])) * 2 + i;
		return longint'({ddr_pkg::DDR_WINDOW, hw[25:2], 3'(lane_byte)});
	endfunction

	function automatic logic [7:0] shadow_byte(input longint key);
		logic [28:0] w;
		logic [63:0] init;
		if (shadow.exists(key))
			return shadow[key];
		w = 29'(key >> 3);
		init = {w, 3'b011, ~w, 3'b110};
		return init[int'(key[2:0])*8 +: 8];
	endfunction

	function automatic logic [31:0] expected_word(input int c, input logic [17:0] a);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < ((c == 0) ? 4 : 2); i++)
			r[i*8 +: 8] = shadow_byte(byte_key(c, a, i));
		return r;
	endfunction

	function automatic logic [31:0] data_for(input int n);
		return 32'(n) * 32'h9E3779B1 + 32'h00C0FFEE;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic client_write(input int c, input logic [17:0] a, input logic [31:0] d,
			input logic [3:0] be);
		while (busy_of(c))
			@(negedge CLK);
		case (c)
			0: begin
				ramh_addr = a;
				ramh_din = d;
				ramh_wr = be;
			end
			1: begin
				cdram_addr = a;
				cdram_din = d[15:0];
				cdram_wr = be[1:0];
			end
			default: begin
				vdp1fb_addr = a;
				vdp1fb_din = d[15:0];
				vdp1fb_wr = be[1:0];
			end
		endcase
		for (int i = 0; i < ((c == 0) ? 4 : 2); i++)
			if (be[i])
				shadow[byte_key(c, a, i)] = d[i*8 +: 8];
		@(negedge CLK);
		ramh_wr = '0;
		cdram_wr = '0;
		vdp1fb_wr = '0;
		@(negedge CLK);
	endtask

	task automatic client_read(input int c, input logic [17:0] a, output logic saw_busy);
		saw_busy = 1'b0;
		case (c)
			0: begin
				ramh_addr = a;
				ramh_rd = 1'b1;
			end
			1: begin
				cdram_addr = a;
				cdram_rd = 1'b1;
			end
			default: begin
				vdp1fb_addr = a;
				vdp1fb_rd = 1'b1;
			end
		endcase
		@(negedge CLK);
		while (busy_of(c)) begin
			saw_busy = 1'b1;
			@(negedge CLK);
		end
		name_q.push_back($sformatf("%s_dout addr %h", client_name(c), a));
		got_q.push_back(dout_of(c));
		exp_q.push_back(expected_word(c, a));
		ramh_rd = 1'b0;
		cdram_rd = 1'b0;
		vdp1fb_rd = 1'b0;
		@(negedge CLK);
	endtask

	task automatic fill_until_busy(input int c, input int depth, input logic [17:0] base);
		int n;
		n = 0;
		while (!busy_of(c) && n < 16) begin
			client_write(c, base + 18'(n * 5), data_for(n + 100 * c), 4'hF);
			rec_c.push_back(c);
			rec_a.push_back(base + 18'(n * 5));
			n++;
		end
		check_value({client_name(c), "_busy writes before rise"}, 64'(n), 64'(depth));
	endtask

	task automatic read_back_records;
		logic b;
		while (rec_c.size() > 0)
			client_read(rec_c.pop_front(), rec_a.pop_front(), b);
	endtask

	// compares what the read task captured against the reference
	always @(posedge CLK) begin
		while (got_q.size() > 0)
			check_value(name_q.pop_front(), 64'(got_q.pop_front()), 64'(exp_q.pop_front()));
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic saw;
		logic [17:0] a;
		CLK = 1'b0;
		rst_pulse = 1'b1;
		cycles = 0;
		ramh_addr = '0;
		ramh_din = '0;
		ramh_rd = 1'b0;
		ramh_wr = '0;
		cdram_addr = '0;
		cdram_din = '0;
		cdram_rd = 1'b0;
		cdram_wr = '0;
		vdp1fb_addr = '0;
		vdp1fb_din = '0;
		vdp1fb_rd = 1'b0;
		vdp1fb_wr = '0;
		random_busy = 1'b0;
		hold_busy = 1'b0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		rst_pulse = 1'b0;
		@(negedge CLK);

		check_value("ramh_busy", 64'(ramh_busy), 64'd0);
		check_value("cdram_busy", 64'(cdram_busy), 64'd0);
		check_value("vdp1fb_busy", 64'(vdp1fb_busy), 64'd0);
		for (int c = 0; c < 3; c++) begin
			a = 18'h00010 + 18'(c * 16);
			client_read(c, a, saw);
			check_value({client_name(c), "_busy on first read"}, 64'(saw), 64'd1);
			// full write, then partial write, then a hit in the same line
			client_write(c, a, data_for(c), 4'hF);
			client_read(c, a, saw);
			client_write(c, a + 18'd1, data_for(c + 7), (c == 0) ? 4'b0101 : 4'b0010);
			client_read(c, a + 18'd1, saw);
			client_read(c, a + 18'd2, saw);
			check_value({client_name(c), "_busy on line hit"}, 64'(saw), 64'd0);
		end

		random_busy = 1'b1;
		for (int i = 0; i < 24; i++) begin
			a = 18'h00200 + 18'(i * 37);
			client_write(i % 3, a, data_for(i + 50), 4'hF);
			rec_c.push_back(i % 3);
			rec_a.push_back(a);
		end
		read_back_records();

		// let any write in flight drain before the FIFOs are stacked
		random_busy = 1'b0;
		repeat (6) @(negedge CLK);
		hold_busy = 1'b1;
		@(negedge CLK);
		fill_until_busy(0, 8, 18'h01000);
		fill_until_busy(1, 2, 18'h01000);
		fill_until_busy(2, 4, 18'h01000);
		hold_busy = 1'b0;
		random_busy = 1'b1;
		for (int i = 0; i < 9; i++) begin
			a = 18'h02000 + 18'(i * 11);
			client_write(i % 3, a, data_for(i + 300), 4'hF);
			rec_c.push_back(i % 3);
			rec_a.push_back(a);
		end
		read_back_records();
		repeat (2) @(negedge CLK);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: ddr_mem_model.sv
// testbench DDR memory, random busy and burst read return with gaps, unwritten words hold a pattern
`default_nettype none
`timescale 1ns/1ps

module ddr_mem_model (
	input wire CLK,
	input wire random_busy,
	input wire hold_busy,
	input wire [28:0] addr,
	input wire [7:0] burstcnt,
	input wire [7:0] be,
	input wire [63:0] din,
	input wire rd,
	input wire we,
	output logic busy,
	output logic [63:0] dout,
	output logic dout_ready
);

	logic [63:0] mem [logic [28:0]];
	logic [31:0] rng;
	logic [28:0] burst_addr;
	int burst_left;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// pattern of a word never written
	function automatic logic [63:0] read_word(input logic [28:0] w);
		if (mem.exists(w))
			return mem[w];
		return {w, 3'b011, ~w, 3'b110};
	endfunction

	initial begin
		rng = 32'd58;
		burst_left = 0;
		burst_addr = '0;
		busy = 1'b0;
		dout = '0;
		dout_ready = 1'b0;
	end

	// commands and fill beats count only when busy is low at the edge
	always @(posedge CLK) begin
		logic [63:0] word;
		if (!busy) begin
			if (dout_ready && burst_left > 0) begin
				burst_addr = burst_addr + 29'd1;
				burst_left = burst_left - 1;
			end
			if (we) begin
				word = read_word(addr);
				for (int k = 0; k < 8; k++)
					if (be[k])
						word[k*8 +: 8] = din[k*8 +: 8];
				mem[addr] = word;
			end
			if (rd) begin
				burst_addr = addr;
				burst_left = int'(burstcnt);
			end
		end
	end

	always @(negedge CLK) begin
		rng = xorshift32(rng);
		busy = hold_busy || (random_busy && rng[1:0] == 2'b00);
		dout_ready = (burst_left > 0) && (rng[3:2] != 2'b00);
		dout = dout_ready ? read_word(burst_addr) : 64'h0;
	end

endmodule

`default_nettype wire

// File: ddram.sv
// DDR front end top, three emulator clients share one 64-bit DDR port via caches, FIFOs and arbiter
`default_nettype none
`timescale 1ns/1ps

module ddram #(
	parameter int RAMH_FIFO_LOG2 = 3,
	parameter int CDRAM_FIFO_LOG2 = 1,
	parameter int VDP1FB_FIFO_LOG2 = 2,
	parameter int RAMH_LINE_LOG2 = 2,
	parameter int CDRAM_LINE_LOG2 = 1,
	parameter int VDP1FB_LINE_LOG2 = 2
) (
	input wire CLK,
	input wire rst_pulse,

	input wire [17:0] ramh_addr,
	input wire [31:0] ramh_din,
	input wire ramh_rd,
	input wire [3:0] ramh_wr,
	output logic [31:0] ramh_dout,
	output logic ramh_busy,

	input wire [17:0] cdram_addr,
	input wire [15:0] cdram_din,
	input wire cdram_rd,
	input wire [1:0] cdram_wr,
	output logic [15:0] cdram_dout,
	output logic cdram_busy,

	input wire [17:0] vdp1fb_addr,
	input wire [15:0] vdp1fb_din,
	input wire vdp1fb_rd,
	input wire [1:0] vdp1fb_wr,
	output logic [15:0] vdp1fb_dout,
	output logic vdp1fb_busy,

	input wire DDRAM_BUSY,
	output logic [ddr_pkg::DDR_BURST_W-1:0] DDRAM_BURSTCNT,
	output logic [ddr_pkg::DDR_ADDR_W-1:0] DDRAM_ADDR,
	input wire [ddr_pkg::DDR_DATA_W-1:0] DDRAM_DOUT,
	input wire DDRAM_DOUT_READY,
	output logic DDRAM_RD,
	output logic [ddr_pkg::DDR_DATA_W-1:0] DDRAM_DIN,
	output logic [ddr_pkg::DDR_BE_W-1:0] DDRAM_BE,
	output logic DDRAM_WE
);

	localparam int RAMH_TAG_W = 17 - RAMH_LINE_LOG2;
	localparam int CDRAM_TAG_W = 16 - CDRAM_LINE_LOG2;
	localparam int VDP1FB_TAG_W = 16 - VDP1FB_LINE_LOG2;

	logic [2:0] wr_old;
	logic ramh_push, cdram_push, vdp1fb_push;
	ddr_pkg::ramh_wreq_t ramh_head;
	ddr_pkg::word16_wreq_t cdram_head, vdp1fb_head;
	logic ramh_empty, cdram_empty, vdp1fb_empty;
	logic ramh_full, cdram_full, vdp1fb_full;
	logic ramh_pop, cdram_pop, vdp1fb_pop;
	logic ramh_read_busy, cdram_read_busy, vdp1fb_read_busy;
	logic ramh_fill_done, cdram_fill_done, vdp1fb_fill_done;
	logic [RAMH_TAG_W-1:0] ramh_tag;
	logic [CDRAM_TAG_W-1:0] cdram_tag;
	logic [VDP1FB_TAG_W-1:0] vdp1fb_tag;
	logic [2:0] fill_en;
	logic [ddr_pkg::DDR_BURST_W-1:0] fill_addr;
	logic [ddr_pkg::DDR_DATA_W-1:0] fill_data;

	// a rising write strobe posts one entry
	always_ff @(posedge CLK) begin
		if (rst_pulse)
			wr_old <= '0;
		else
			wr_old <= {|vdp1fb_wr, |cdram_wr, |ramh_wr};
	end

	assign ramh_push = (|ramh_wr) && !wr_old[0];
	assign cdram_push = (|cdram_wr) && !wr_old[1];
	assign vdp1fb_push = (|vdp1fb_wr) && !wr_old[2];

	ddr_write_fifo #(.FIFO_DEPTH_LOG2(RAMH_FIFO_LOG2), .payload_t(ddr_pkg::ramh_wreq_t))
	u_ramh_fifo (
		.CLK(CLK), .rst_pulse(rst_pulse), .wdata({ramh_addr, ramh_wr, ramh_din}),
		.push(ramh_push), .pop(ramh_pop), .rdata(ramh_head),
		.empty(ramh_empty), .full(ramh_full)
	);

	ddr_write_fifo #(.FIFO_DEPTH_LOG2(CDRAM_FIFO_LOG2), .payload_t(ddr_pkg::word16_wreq_t))
	u_cdram_fifo (
		.CLK(CLK), .rst_pulse(rst_pulse), .wdata({cdram_addr, cdram_wr, cdram_din}),
		.push(cdram_push), .pop(cdram_pop), .rdata(cdram_head),
		.empty(cdram_empty), .full(cdram_full)
	);

	ddr_write_fifo #(.FIFO_DEPTH_LOG2(VDP1FB_FIFO_LOG2), .payload_t(ddr_pkg::word16_wreq_t))
	u_vdp1fb_fifo (
		.CLK(CLK), .rst_pulse(rst_pulse), .wdata({vdp1fb_addr, vdp1fb_wr, vdp1fb_din}),
		.push(vdp1fb_push), .pop(vdp1fb_pop), .rdata(vdp1fb_head),
		.empty(vdp1fb_empty), .full(vdp1fb_full)
	);

	ddr_line_cache #(.ADDR_W(18), .WORD_W(32), .LINE_WORDS_LOG2(RAMH_LINE_LOG2)) u_ramh_cache (
		.CLK(CLK), .rst_pulse(rst_pulse), .addr(ramh_addr), .rd(ramh_rd), .wr(ramh_wr),
		.read_busy(ramh_read_busy), .line_tag(ramh_tag), .fill_en(fill_en[0]),
		.fill_addr(fill_addr), .fill_data(fill_data), .fill_done(ramh_fill_done),
		.dout(ramh_dout)
	);

	ddr_line_cache #(.ADDR_W(18), .WORD_W(16), .LINE_WORDS_LOG2(CDRAM_LINE_LOG2)) u_cdram_cache (
		.CLK(CLK), .rst_pulse(rst_pulse), .addr(cdram_addr), .rd(cdram_rd), .wr(cdram_wr),
		.read_busy(cdram_read_busy), .line_tag(cdram_tag), .fill_en(fill_en[1]),
		.fill_addr(fill_addr), .fill_data(fill_data), .fill_done(cdram_fill_done),
		.dout(cdram_dout)
	);

	ddr_line_cache #(.ADDR_W(18), .WORD_W(16), .LINE_WORDS_LOG2(VDP1FB_LINE_LOG2))
	u_vdp1fb_cache (
		.CLK(CLK), .rst_pulse(rst_pulse), .addr(vdp1fb_addr), .rd(vdp1fb_rd), .wr(vdp1fb_wr),
		.read_busy(vdp1fb_read_busy), .line_tag(vdp1fb_tag), .fill_en(fill_en[2]),
		.fill_addr(fill_addr), .fill_data(fill_data), .fill_done(vdp1fb_fill_done),
		.dout(vdp1fb_dout)
	);

	ddr_arbiter #(
		.RAMH_LINE_LOG2(RAMH_LINE_LOG2),
		.CDRAM_LINE_LOG2(CDRAM_LINE_LOG2),
		.VDP1FB_LINE_LOG2(VDP1FB_LINE_LOG2)
	) u_arbiter (
		.CLK(CLK), .rst_pulse(rst_pulse),
		.ramh_whead(ramh_head), .ramh_empty(ramh_empty), .ramh_pop(ramh_pop),
		.ramh_read_busy(ramh_read_busy), .ramh_line_tag(ramh_tag),
		.ramh_fill_done(ramh_fill_done),
		.cdram_whead(cdram_head), .cdram_empty(cdram_empty), .cdram_pop(cdram_pop),
		.cdram_read_busy(cdram_read_busy), .cdram_line_tag(cdram_tag),
		.cdram_fill_done(cdram_fill_done),
		.vdp1fb_whead(vdp1fb_head), .vdp1fb_empty(vdp1fb_empty), .vdp1fb_pop(vdp1fb_pop),
		.vdp1fb_read_busy(vdp1fb_read_busy), .vdp1fb_line_tag(vdp1fb_tag),
		.vdp1fb_fill_done(vdp1fb_fill_done),
		.fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data),
		.ddr_busy(DDRAM_BUSY), .ddr_dout(DDRAM_DOUT), .ddr_dout_ready(DDRAM_DOUT_READY),
		.ddr_addr(DDRAM_ADDR), .ddr_burstcnt(DDRAM_BURSTCNT), .ddr_be(DDRAM_BE),
		.ddr_din(DDRAM_DIN), .ddr_rd(DDRAM_RD), .ddr_we(DDRAM_WE)
	);

	assign ramh_busy = ramh_full | ramh_read_busy;
	assign cdram_busy = cdram_full | cdram_read_busy;
	assign vdp1fb_busy = vdp1fb_full | vdp1fb_read_busy;

endmodule

`default_nettype wire

// File: ddr_arbiter.sv
// fixed-priority arbiter that ddram instantiates once to issue client writes and line bursts
`default_nettype none
`timescale 1ns/1ps

module ddr_arbiter #(
	parameter int RAMH_LINE_LOG2 = 2,
	parameter int CDRAM_LINE_LOG2 = 1,
	parameter int VDP1FB_LINE_LOG2 = 2,
	// tags of the 18-bit client word addresses
	localparam int RAMH_TAG_W = 17 - RAMH_LINE_LOG2,
	localparam int CDRAM_TAG_W = 16 - CDRAM_LINE_LOG2,
	localparam int VDP1FB_TAG_W = 16 - VDP1FB_LINE_LOG2
) (
	input wire CLK,
	input wire rst_pulse,

	input wire ddr_pkg::ramh_wreq_t ramh_whead,
	input wire ramh_empty,
	output logic ramh_pop,
	input wire ramh_read_busy,
	input wire [RAMH_TAG_W-1:0] ramh_line_tag,
	output logic ramh_fill_done,

	input wire ddr_pkg::word16_wreq_t cdram_whead,
	input wire cdram_empty,
	output logic cdram_pop,
	input wire cdram_read_busy,
	input wire [CDRAM_TAG_W-1:0] cdram_line_tag,
	output logic cdram_fill_done,

	input wire ddr_pkg::word16_wreq_t vdp1fb_whead,
	input wire vdp1fb_empty,
	output logic vdp1fb_pop,
	input wire vdp1fb_read_busy,
	input wire [VDP1FB_TAG_W-1:0] vdp1fb_line_tag,
	output logic vdp1fb_fill_done,

	output logic [2:0] fill_en,
	output logic [ddr_pkg::DDR_BURST_W-1:0] fill_addr,
	output logic [ddr_pkg::DDR_DATA_W-1:0] fill_data,

	input wire ddr_busy,
	input wire [ddr_pkg::DDR_DATA_W-1:0] ddr_dout,
	input wire ddr_dout_ready,
	output logic [ddr_pkg::DDR_ADDR_W-1:0] ddr_addr,
	output logic [ddr_pkg::DDR_BURST_W-1:0] ddr_burstcnt,
	output logic [ddr_pkg::DDR_BE_W-1:0] ddr_be,
	output logic [ddr_pkg::DDR_DATA_W-1:0] ddr_din,
	output logic ddr_rd,
	output logic ddr_we
);

	typedef logic [ddr_pkg::RAM_ADDR_W-1:0] hw_addr_t;
	typedef logic [ddr_pkg::DDR_BURST_W-1:0] burst_t;

	ddr_pkg::arb_state_t state;
	ddr_pkg::chan_t chan;
	burst_t word_cnt;
	logic fill_beat;
	logic fill_last;

	logic pick_we;
	logic pick_rd;
	ddr_pkg::chan_t pick_chan;
	hw_addr_t pick_hw;
	logic [ddr_pkg::DDR_BE_W-1:0] pick_be;
	logic [ddr_pkg::DDR_DATA_W-1:0] pick_din;
	burst_t pick_burst;

	// priority order is ramh wr, ramh rd, cdram wr, cdram rd, vdp1fb wr, vdp1fb rd
	always_comb begin
		pick_we = 1'b0;
		pick_rd = 1'b0;
		pick_chan = ddr_pkg::CH_RAMH;
		pick_hw = '0;
		pick_be = '1;
		pick_din = '0;
		pick_burst = burst_t'(1);
		if (!ramh_empty) begin
			pick_we = 1'b1;
			pick_hw = hw_addr_t'({ramh_whead.addr, 1'b0}) | ddr_pkg::RAMH_BASE;
			pick_be = {ramh_whead.be, 4'b0000} >> {ramh_whead.addr[0], 2'b00};
			pick_din = {2{ramh_whead.data}};
		end else if (ramh_read_busy) begin
			pick_rd = 1'b1;
			pick_hw = hw_addr_t'({ramh_line_tag, {(RAMH_LINE_LOG2 + 2){1'b0}}})
				| ddr_pkg::RAMH_BASE;
			pick_burst = burst_t'(1) << RAMH_LINE_LOG2;
		end else if (!cdram_empty) begin
			pick_we = 1'b1;
			pick_chan = ddr_pkg::CH_CDRAM;
			pick_hw = hw_addr_t'(cdram_whead.addr) | ddr_pkg::CDRAM_BASE;
			pick_be = {cdram_whead.be, 6'b000000} >> {cdram_whead.addr[1:0], 1'b0};
			pick_din = {4{cdram_whead.data}};
		end else if (cdram_read_busy) begin
			pick_rd = 1'b1;
			pick_chan = ddr_pkg::CH_CDRAM;
			pick_hw = hw_addr_t'({cdram_line_tag, {(CDRAM_LINE_LOG2 + 2){1'b0}}})
				| ddr_pkg::CDRAM_BASE;
			pick_burst = burst_t'(1) << CDRAM_LINE_LOG2;
		end else if (!vdp1fb_empty) begin
			pick_we = 1'b1;
			pick_chan = ddr_pkg::CH_VDP1FB;
			pick_hw = hw_addr_t'(vdp1fb_whead.addr) | ddr_pkg::VDP1FB_BASE;
			pick_be = {vdp1fb_whead.be, 6'b000000} >> {vdp1fb_whead.addr[1:0], 1'b0};
			pick_din = {4{vdp1fb_whead.data}};
		end else if (vdp1fb_read_busy) begin
			pick_rd = 1'b1;
			pick_chan = ddr_pkg::CH_VDP1FB;
			pick_hw = hw_addr_t'({vdp1fb_line_tag, {(VDP1FB_LINE_LOG2 + 2){1'b0}}})
				| ddr_pkg::VDP1FB_BASE;
			pick_burst = burst_t'(1) << VDP1FB_LINE_LOG2;
		end
	end

	// everything holds while the DDR port is busy
	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			state <= ddr_pkg::ARB_IDLE;
			chan <= ddr_pkg::CH_RAMH;
			word_cnt <= '0;
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;
		end else if (!ddr_busy) begin
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;
			case (state)
				ddr_pkg::ARB_IDLE: if (pick_we || pick_rd) begin
					ddr_addr <= {ddr_pkg::DDR_WINDOW, pick_hw[ddr_pkg::RAM_ADDR_W-1:2]};
					ddr_be <= pick_be;
					ddr_din <= pick_din;
					ddr_burstcnt <= pick_burst;
					ddr_we <= pick_we;
					ddr_rd <= pick_rd;
					chan <= pick_chan;
					word_cnt <= '0;
					state <= pick_we ? ddr_pkg::ARB_WRITE : ddr_pkg::ARB_FILL;
				end
				ddr_pkg::ARB_WRITE: state <= ddr_pkg::ARB_IDLE;
				ddr_pkg::ARB_FILL: if (ddr_dout_ready) begin
					word_cnt <= word_cnt + 1'b1;
					if (fill_last)
						state <= ddr_pkg::ARB_IDLE;
				end
				default: state <= ddr_pkg::ARB_IDLE;
			endcase
		end
	end

	// pop in the cycle the write beat is taken
	assign ramh_pop = state == ddr_pkg::ARB_WRITE && !ddr_busy && chan == ddr_pkg::CH_RAMH;
	assign cdram_pop = state == ddr_pkg::ARB_WRITE && !ddr_busy && chan == ddr_pkg::CH_CDRAM;
	assign vdp1fb_pop = state == ddr_pkg::ARB_WRITE && !ddr_busy && chan == ddr_pkg::CH_VDP1FB;

	assign fill_beat = state == ddr_pkg::ARB_FILL && ddr_dout_ready && !ddr_busy;
	assign fill_last = (word_cnt == ddr_burstcnt - 1'b1);
	assign fill_en = fill_beat ? (3'b001 << chan) : 3'b000;
	assign fill_addr = word_cnt;
	assign fill_data = ddr_dout;

	assign ramh_fill_done = fill_en[0] && fill_last;
	assign cdram_fill_done = fill_en[1] && fill_last;
	assign vdp1fb_fill_done = fill_en[2] && fill_last;

	// the memory may only return words of a burst that was issued
	assert property (@(posedge CLK) disable iff (rst_pulse)
		ddr_dout_ready && !ddr_busy |-> state == ddr_pkg::ARB_FILL)
		else $error("fill word returned with no burst outstanding");

endmodule

`default_nettype wire

// File: ddr_line_cache.sv
// single-line read cache for one client, filled by the arbiter and read by lane
`default_nettype none
`timescale 1ns/1ps

module ddr_line_cache #(
	parameter int ADDR_W = 18,
	parameter int WORD_W = 16,
	parameter int LINE_WORDS_LOG2 = 2,
	localparam int LANE_W = $clog2(ddr_pkg::DDR_DATA_W / WORD_W),
	localparam int TAG_W = ADDR_W - LANE_W - LINE_WORDS_LOG2
) (
	input wire CLK,
	input wire rst_pulse,
	input wire [ADDR_W-1:0] addr,
	input wire rd,
	input wire [WORD_W/8-1:0] wr,
	output logic read_busy,
	output logic [TAG_W-1:0] line_tag,
	input wire fill_en,
	input wire [ddr_pkg::DDR_BURST_W-1:0] fill_addr,
	input wire [ddr_pkg::DDR_DATA_W-1:0] fill_data,
	input wire fill_done,
	output logic [WORD_W-1:0] dout
);

	localparam int LANES = ddr_pkg::DDR_DATA_W / WORD_W;
	localparam int OFFS_W = LANE_W + LINE_WORDS_LOG2;

	logic rd_old;
	logic wr_old;
	logic rd_edge;
	logic wr_edge;
	logic dirty;
	logic [ADDR_W-1:0] held_addr;
	logic [ddr_pkg::DDR_DATA_W-1:0] line_ram [2 ** LINE_WORDS_LOG2];
	logic [ddr_pkg::DDR_DATA_W-1:0] line_q;
	logic [LANE_W-1:0] lane;

	assign rd_edge = rd && !rd_old;
	assign wr_edge = (|wr) && !wr_old;
	assign line_tag = held_addr[ADDR_W-1:OFFS_W];

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			rd_old <= 1'b0;
			wr_old <= 1'b0;
			dirty <= 1'b1;
			read_busy <= 1'b0;
		end else begin
			rd_old <= rd;
			wr_old <= |wr;
			if (rd_edge) begin
				if (addr[ADDR_W-1:OFFS_W] != line_tag || dirty)
					read_busy <= 1'b1;
				dirty <= 1'b0;
			end
			// a write into the held line forces the next read to refetch
			if (wr_edge && addr[ADDR_W-1:OFFS_W] == line_tag)
				dirty <= 1'b1;
			if (fill_done)
				read_busy <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_edge)
			held_addr <= addr;
		if (fill_en)
			line_ram[fill_addr[LINE_WORDS_LOG2-1:0]] <= fill_data;
	end

	// lowest address sits in the high lane
	assign line_q = line_ram[held_addr[OFFS_W-1:LANE_W]];
	assign lane = held_addr[LANE_W-1:0];
	assign dout = line_q[(LANES - 1 - int'(lane)) * WORD_W +: WORD_W];

	assert property (@(posedge CLK) disable iff (rst_pulse) fill_en |-> read_busy)
		else $error("fill word arrived for a client with no pending read");

endmodule

`default_nettype wire

// File: ddr_write_fifo.sv
// posted-write FIFO between one client and the DDR arbiter, head visible without delay
`default_nettype none
`timescale 1ns/1ps

module ddr_write_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 3,
	parameter type payload_t = logic [53:0]
) (
	input wire CLK,
	input wire rst_pulse,
	input wire payload_t wdata,
	input wire push,
	input wire pop,
	output payload_t rdata,
	output logic empty,
	output logic full
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

	payload_t mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (!do_push && do_pop)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = count[FIFO_DEPTH_LOG2];

	// the client is expected to hold off while its busy is high
	assert property (@(posedge CLK) disable iff (rst_pulse) push |-> !full)
		else $error("write pushed into a full FIFO");

endmodule

`default_nettype wire

// File: ddr_pkg.sv
// shared DDR geometry, client regions, arbiter types and write-request layouts for the DDR front end
`default_nettype none

package ddr_pkg;

	localparam int DDR_DATA_W = 64;
	localparam int DDR_ADDR_W = 29;
	localparam int DDR_BE_W = 8;
	localparam int DDR_BURST_W = 8;

	// internal space counts 16-bit half-words
	localparam int RAM_ADDR_W = 26;

	// RAM sits at byte 0x30000000 in the DDR map
	localparam logic [DDR_ADDR_W-RAM_ADDR_W+1:0] DDR_WINDOW = 5'd6;

	// region bases inside the half-word space
	localparam logic [RAM_ADDR_W-1:0] RAMH_BASE = 26'h0180000;
	localparam logic [RAM_ADDR_W-1:0] CDRAM_BASE = 26'h0400000;
	localparam logic [RAM_ADDR_W-1:0] VDP1FB_BASE = 26'h0240000;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE,
		ARB_FILL
	} arb_state_t;

	typedef logic [1:0] chan_t;

	localparam chan_t CH_RAMH = 2'd0;
	localparam chan_t CH_CDRAM = 2'd1;
	localparam chan_t CH_VDP1FB = 2'd2;

	// address is the client word address
	typedef struct packed {
		logic [17:0] addr;
		logic [3:0] be;
		logic [31:0] data;
	} ramh_wreq_t;

	typedef struct packed {
		logic [17:0] addr;
		logic [1:0] be;
		logic [15:0] data;
	} word16_wreq_t;

endpackage

`default_nettype wire
